// File: maze_pkg.sv
`default_nettype none

package maze_pkg;

    localparam int SCREEN_W       = 320;
    localparam int SCREEN_H       = 180;
    localparam int SPRITE_SIZE    = 32;
    localparam int POS_X_MAX      = SCREEN_W - SPRITE_SIZE;  // 288
    localparam int POS_Y_MAX      = SCREEN_H - SPRITE_SIZE;  // 148
    localparam int BALL_START_X   = POS_X_MAX / 2;
    localparam int BALL_START_Y   = POS_Y_MAX / 2;
    localparam int FAIL_HOLES     = 7;
    localparam int NUM_HOLES      = FAIL_HOLES + 1;  // last index is the win hole
    localparam int NUM_COORDS     = 2 * (NUM_HOLES + 1);  // holes plus start, x and y each
    localparam int CAPTURE_RADIUS = 14;
    localparam int TILT_SHIFT     = 2;
    localparam int CLASSIC_LEVELS = 4;

    typedef logic [9:0]        coord_t;
    typedef logic signed [7:0] tilt_t;
    typedef logic [1:0]        level_t;
    typedef logic [1:0]        sel_t;
    typedef logic [15:0]       lfsr_t;

    localparam lfsr_t LFSR_SEED_INIT = 16'hace1;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pos_t;

    typedef struct packed {
        pos_t [FAIL_HOLES-1:0] fail;
        pos_t                  win;
        pos_t                  start;
    } layout_t;

    localparam pos_t BALL_START = '{x: coord_t'(BALL_START_X), y: coord_t'(BALL_START_Y)};

    typedef enum logic [3:0] {
        MENU, NEW_RST, NEW, BALL_RST, AGAIN, PLAYING, PAUSE, FAIL, WIN, FINISH
    } game_state_e;

    typedef enum logic {
        CLASSIC, ENDLESS
    } mode_e;

    // start kept clear of every hole so a fresh ball never drops at once
    localparam layout_t CLASSIC_TABLE [CLASSIC_LEVELS] = '{
        '{fail:  '{'{10'd20, 10'd20}, '{10'd80, 10'd120}, '{10'd140, 10'd10},
                   '{10'd200, 10'd130}, '{10'd260, 10'd20}, '{10'd40, 10'd90},
                   '{10'd230, 10'd70}},
          win:   '{10'd270, 10'd130},
          start: '{10'd144, 10'd74}},
        '{fail:  '{'{10'd80, 10'd30}, '{10'd80, 10'd110}, '{10'd150, 10'd60},
                   '{10'd150, 10'd140}, '{10'd220, 10'd20}, '{10'd220, 10'd100},
                   '{10'd280, 10'd60}},
          win:   '{10'd280, 10'd140},
          start: '{10'd20, 10'd74}},
        '{fail:  '{'{10'd30, 10'd30}, '{10'd100, 10'd80}, '{10'd190, 10'd80},
                   '{10'd260, 10'd30}, '{10'd60, 10'd140}, '{10'd230, 10'd140},
                   '{10'd144, 10'd20}},
          win:   '{10'd144, 10'd74},
          start: '{10'd144, 10'd130}},
        '{fail:  '{'{10'd60, 10'd10}, '{10'd10, 10'd70}, '{10'd120, 10'd60},
                   '{10'd180, 10'd120}, '{10'd240, 10'd40}, '{10'd100, 10'd140},
                   '{10'd270, 10'd100}},
          win:   '{10'd280, 10'd140},
          start: '{10'd10, 10'd10}}
    };

    // number of entries on each menu screen
    function automatic sel_t max_option(game_state_e state, mode_e mode);
        case (state)
            MENU:    return 2'd2;  // classic, endless
            PAUSE:   return (mode == ENDLESS) ? 2'd3 : 2'd2;
            FAIL:    return (mode == ENDLESS) ? 2'd2 : 2'd1;
            WIN:     return 2'd2;
            FINISH:  return 2'd1;
            default: return 2'd1;  // no menu shown
        endcase
    endfunction

endpackage

`default_nettype wire

// File: layout_gen.sv
`timescale 1ns/1ns
`default_nettype none

module layout_gen (
    input  wire                     CLK,
    input  wire                     rst,
    input  wire                     i_req,
    input  wire maze_pkg::mode_e    i_mode,
    input  wire maze_pkg::level_t   i_level,
    output maze_pkg::layout_t       o_layout,
    output logic                    o_ready
);

    maze_pkg::lfsr_t                            lfsr;
    maze_pkg::coord_t [maze_pkg::NUM_COORDS-1:0] coords;  // same bit order as layout_t
    maze_pkg::coord_t                           rand_coord;
    logic [4:0]                                 fill_cnt;
    logic                                       filling;

    // free running, so every endless game starts from a different point
    always_ff @(posedge CLK) begin
        if (rst) begin
            lfsr <= maze_pkg::LFSR_SEED_INIT;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // odd slots hold x, even slots hold y
    assign rand_coord = fill_cnt[0] ? maze_pkg::coord_t'(lfsr % (maze_pkg::POS_X_MAX + 1))
                                    : maze_pkg::coord_t'(lfsr % (maze_pkg::POS_Y_MAX + 1));

    always_ff @(posedge CLK) begin
        if (rst) begin
            o_ready  <= 1'b0;
            filling  <= 1'b0;
            fill_cnt <= '0;
        end else if (i_req) begin
            o_ready  <= (i_mode == maze_pkg::CLASSIC);  // table lookup is done in one cycle
            filling  <= (i_mode == maze_pkg::ENDLESS);
            fill_cnt <= '0;
        end else if (filling) begin
            fill_cnt <= fill_cnt + 5'd1;
            if (fill_cnt == 5'(maze_pkg::NUM_COORDS - 1)) begin
                filling <= 1'b0;
                o_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (i_req && i_mode == maze_pkg::CLASSIC) begin
            coords <= maze_pkg::CLASSIC_TABLE[i_level];
        end else if (filling) begin
            coords[fill_cnt] <= rand_coord;
        end
    end

    assign o_layout = coords;

    // ready comes only from a classic request or from the last endless slot
    assert property (@(posedge CLK) disable iff (rst)
        $rose(o_ready) |-> !filling &&
            ($past(i_req) || $past(fill_cnt) == 5'(maze_pkg::NUM_COORDS - 1)));

endmodule

`default_nettype wire

// File: hole_detector.sv
`timescale 1ns/1ns
`default_nettype none

module hole_detector (
    input  wire                 CLK,
    input  wire                 rst,
    input  wire                 i_arm,
    input  wire maze_pkg::pos_t i_ball,
    input  wire maze_pkg::pos_t i_hole,
    output logic                o_hit
);

    maze_pkg::coord_t dx;
    maze_pkg::coord_t dy;

    assign dx = (i_ball.x > i_hole.x) ? i_ball.x - i_hole.x : i_hole.x - i_ball.x;
    assign dy = (i_ball.y > i_hole.y) ? i_ball.y - i_hole.y : i_hole.y - i_ball.y;

    // square capture box around the hole
    always_ff @(posedge CLK) begin
        if (rst) begin
            o_hit <= 1'b0;
        end else begin
            o_hit <= i_arm && (dx < maze_pkg::CAPTURE_RADIUS)
                           && (dy < maze_pkg::CAPTURE_RADIUS);
        end
    end

endmodule

`default_nettype wire

// File: drop_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module drop_arbiter (
    input  wire                            CLK,
    input  wire                            rst,
    input  wire [maze_pkg::NUM_HOLES-1:0]  i_hits,
    input  wire maze_pkg::layout_t         i_layout,
    output logic                           o_fail,
    output logic                           o_win,
    output maze_pkg::pos_t                 o_drop
);

    maze_pkg::pos_t [maze_pkg::NUM_HOLES-1:0] holes;
    maze_pkg::pos_t                           hit_pos;

    assign holes  = {i_layout.win, i_layout.fail};
    assign o_fail = |i_hits[maze_pkg::FAIL_HOLES-1:0];
    assign o_win  = i_hits[maze_pkg::NUM_HOLES-1] && !o_fail;  // a fail hole takes priority

    // lowest hit index wins
    always_comb begin
        hit_pos = holes[maze_pkg::NUM_HOLES-1];
        for (int i = maze_pkg::NUM_HOLES - 1; i >= 0; i--) begin
            if (i_hits[i]) begin
                hit_pos = holes[i];
            end
        end
    end

    // latched on the edge the FSM leaves PLAYING
    always_ff @(posedge CLK) begin
        if (rst) begin
            o_drop <= maze_pkg::BALL_START;
        end else if (|i_hits) begin
            o_drop <= hit_pos;
        end
    end

endmodule

`default_nettype wire

// File: ball_motion.sv
`timescale 1ns/1ns
`default_nettype none

module ball_motion (
    input  wire                   CLK,
    input  wire                   rst,
    input  wire                   i_load,
    input  wire maze_pkg::pos_t   i_start,
    input  wire                   i_enable,
    input  wire                   i_frame,
    input  wire maze_pkg::tilt_t  i_tilt_x,
    input  wire maze_pkg::tilt_t  i_tilt_y,
    output maze_pkg::pos_t        o_pos
);

    // one axis step, saturated to 0..lim
    function automatic maze_pkg::coord_t step(maze_pkg::coord_t c, maze_pkg::tilt_t t,
                                              maze_pkg::coord_t lim);
        logic signed [11:0] sum;
        sum = $signed({2'b00, c}) + (t >>> maze_pkg::TILT_SHIFT);
        if (sum < 0) begin
            return '0;
        end else if (sum > $signed({2'b00, lim})) begin
            return lim;
        end
        return sum[9:0];
    endfunction

    always_ff @(posedge CLK) begin
        if (rst) begin
            o_pos <= maze_pkg::BALL_START;
        end else if (i_load) begin
            o_pos <= i_start;
        end else if (i_frame && i_enable) begin
            o_pos.x <= step(o_pos.x, i_tilt_x, maze_pkg::coord_t'(maze_pkg::POS_X_MAX));
            o_pos.y <= step(o_pos.y, i_tilt_y, maze_pkg::coord_t'(maze_pkg::POS_Y_MAX));
        end
    end

    // also covers the start points that layout_gen hands over
    assert property (@(posedge CLK) disable iff (rst)
        (o_pos.x <= maze_pkg::POS_X_MAX) && (o_pos.y <= maze_pkg::POS_Y_MAX));

endmodule

`default_nettype wire

// File: game_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module game_fsm (
    input  wire                      CLK,
    input  wire                      rst,
    input  wire                      i_up,
    input  wire                      i_down,
    input  wire                      i_ok,
    input  wire                      i_tilt_valid,
    input  wire                      i_ready,
    input  wire                      i_fail,
    input  wire                      i_win,
    input  wire maze_pkg::pos_t      i_rolling,
    input  wire maze_pkg::pos_t      i_drop,
    input  wire maze_pkg::layout_t   i_layout,
    output maze_pkg::game_state_e    o_state,
    output maze_pkg::mode_e          o_mode,
    output maze_pkg::level_t         o_level,
    output maze_pkg::sel_t           o_sel,
    output logic                     o_req,
    output logic                     o_load,
    output logic                     o_enable,
    output logic                     o_arm,
    output maze_pkg::pos_t           o_ball
);

    maze_pkg::sel_t n_opts;
    logic           tilt_seen;
    logic           last_level;

    assign n_opts     = maze_pkg::max_option(o_state, o_mode);
    assign last_level = (o_level == maze_pkg::level_t'(maze_pkg::CLASSIC_LEVELS - 1));

    // accelerometer alive at least once
    always_ff @(posedge CLK) begin
        if (rst) begin
            tilt_seen <= 1'b0;
        end else if (i_tilt_valid) begin
            tilt_seen <= 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst || i_ok) begin
            o_sel <= '0;
        end else if (i_up && o_sel != '0) begin
            o_sel <= o_sel - 2'd1;
        end else if (i_down && o_sel < n_opts - 2'd1) begin
            o_sel <= o_sel + 2'd1;
        end
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            o_state <= maze_pkg::MENU;
            o_mode  <= maze_pkg::ENDLESS;
            o_level <= '0;
        end else begin
            case (o_state)
                maze_pkg::MENU: begin
                    if (i_ok) begin
                        if (o_sel == '0) begin
                            o_mode <= maze_pkg::CLASSIC;
                        end else begin
                            o_mode <= maze_pkg::ENDLESS;
                        end
                        o_level <= '0;
                        o_state <= maze_pkg::NEW_RST;
                    end
                end
                maze_pkg::NEW_RST: o_state <= maze_pkg::NEW;
                maze_pkg::NEW: begin
                    if (i_ready && (tilt_seen || i_tilt_valid)) begin
                        o_state <= maze_pkg::BALL_RST;
                    end
                end
                maze_pkg::BALL_RST, maze_pkg::AGAIN: o_state <= maze_pkg::PLAYING;
                maze_pkg::PLAYING: begin
                    if (i_fail) begin
                        o_state <= maze_pkg::FAIL;
                    end else if (i_win) begin
                        o_state <= maze_pkg::WIN;
                    end else if (i_ok) begin
                        o_state <= maze_pkg::PAUSE;
                    end
                end
                maze_pkg::PAUSE: begin
                    if (i_ok) begin
                        case (o_sel)
                            2'd0:    o_state <= maze_pkg::PLAYING;
                            2'd1:    o_state <= maze_pkg::AGAIN;
                            default: o_state <= maze_pkg::NEW_RST;  // endless only
                        endcase
                    end
                end
                maze_pkg::FAIL: begin
                    if (i_ok) begin
                        if (o_sel == '0) begin
                            o_state <= maze_pkg::AGAIN;
                        end else begin
                            o_state <= maze_pkg::NEW_RST;
                        end
                    end
                end
                maze_pkg::WIN: begin
                    if (o_mode == maze_pkg::CLASSIC && last_level) begin
                        o_state <= maze_pkg::FINISH;
                    end else if (i_ok) begin
                        if (o_sel == '0) begin
                            o_state <= maze_pkg::AGAIN;
                        end else begin
                            if (o_mode == maze_pkg::CLASSIC) begin
                                o_level <= o_level + 2'd1;  // next level
                            end
                            o_state <= maze_pkg::NEW_RST;
                        end
                    end
                end
                maze_pkg::FINISH: begin
                    if (i_ok) begin
                        o_state <= maze_pkg::MENU;
                    end
                end
                default: o_state <= maze_pkg::MENU;
            endcase
        end
    end

    assign o_req    = (o_state == maze_pkg::NEW_RST);
    assign o_load   = (o_state == maze_pkg::BALL_RST) || (o_state == maze_pkg::AGAIN);
    assign o_enable = (o_state == maze_pkg::MENU) || (o_state == maze_pkg::PLAYING);
    assign o_arm    = (o_state == maze_pkg::PLAYING);

    always_comb begin
        case (o_state)
            maze_pkg::MENU, maze_pkg::PLAYING, maze_pkg::PAUSE: o_ball = i_rolling;
            maze_pkg::FAIL, maze_pkg::WIN, maze_pkg::FINISH:    o_ball = i_drop;  // sits in hole
            default:                                            o_ball = i_layout.start;
        endcase
    end

endmodule

`default_nettype wire

// File: maze_game_top.sv
`timescale 1ns/1ns
`default_nettype none

module maze_game_top (
    input  wire                        CLK,
    input  wire                        rst,
    input  wire maze_pkg::tilt_t       i_tilt_x,
    input  wire maze_pkg::tilt_t       i_tilt_y,
    input  wire                        i_tilt_valid,
    input  wire                        i_frame,
    input  wire                        i_up,
    input  wire                        i_down,
    input  wire                        i_ok,
    output wire maze_pkg::game_state_e o_state,
    output wire maze_pkg::mode_e       o_mode,
    output wire maze_pkg::level_t      o_level,
    output wire maze_pkg::sel_t        o_sel,
    output wire maze_pkg::pos_t        o_ball,
    output wire maze_pkg::layout_t     o_layout
);

    wire                                   req;
    wire                                   ready;
    wire                                   load;
    wire                                   enable;
    wire                                   arm;
    wire                                   fail;
    wire                                   win;
    wire maze_pkg::pos_t                   rolling;
    wire maze_pkg::pos_t                   drop;
    wire [maze_pkg::NUM_HOLES-1:0]         hits;
    wire maze_pkg::pos_t [maze_pkg::NUM_HOLES-1:0] holes;

    layout_gen u_layout (
        .CLK(CLK), .rst(rst),
        .i_req(req), .i_mode(o_mode), .i_level(o_level),
        .o_layout(o_layout), .o_ready(ready)
    );

    assign holes = {o_layout.win, o_layout.fail};  // win hole at the top index

    for (genvar g = 0; g < maze_pkg::NUM_HOLES; g++) begin : g_hole
        hole_detector u_det (
            .CLK(CLK), .rst(rst), .i_arm(arm),
            .i_ball(rolling), .i_hole(holes[g]), .o_hit(hits[g])
        );
    end

    drop_arbiter u_arb (
        .CLK(CLK), .rst(rst),
        .i_hits(hits), .i_layout(o_layout),
        .o_fail(fail), .o_win(win), .o_drop(drop)
    );

    ball_motion u_ball (
        .CLK(CLK), .rst(rst),
        .i_load(load), .i_start(o_layout.start), .i_enable(enable), .i_frame(i_frame),
        .i_tilt_x(i_tilt_x), .i_tilt_y(i_tilt_y), .o_pos(rolling)
    );

    game_fsm u_fsm (
        .CLK(CLK), .rst(rst),
        .i_up(i_up), .i_down(i_down), .i_ok(i_ok), .i_tilt_valid(i_tilt_valid),
        .i_ready(ready), .i_fail(fail), .i_win(win),
        .i_rolling(rolling), .i_drop(drop), .i_layout(o_layout),
        .o_state(o_state), .o_mode(o_mode), .o_level(o_level), .o_sel(o_sel),
        .o_req(req), .o_load(load), .o_enable(enable), .o_arm(arm), .o_ball(o_ball)
    );

endmodule

`default_nettype wire

// File: tb_maze_game.sv
`timescale 1ns/1ns
`default_nettype none

module tb_maze_game;

    logic                  CLK;
    logic                  rst;
    maze_pkg::tilt_t       i_tilt_x;
    maze_pkg::tilt_t       i_tilt_y;
    logic                  i_tilt_valid;
    logic                  i_frame;
    logic                  i_up;
    logic                  i_down;
    logic                  i_ok;
    maze_pkg::game_state_e o_state;
    maze_pkg::mode_e       o_mode;
    maze_pkg::level_t      o_level;
    maze_pkg::sel_t        o_sel;
    maze_pkg::pos_t        o_ball;
    maze_pkg::layout_t     o_layout;

    integer                seed;
    int                    exp_sel;
    maze_pkg::pos_t        model_ball;
    maze_pkg::layout_t     lay;
    maze_pkg::layout_t     first_layout;
    maze_pkg::game_state_e exp_drop;
    logic                  in_play_hole;

    maze_game_top UUT (.*);

    always #10 CLK = ~CLK;

    // square box of the capture radius around a hole
    function automatic logic hole_box(maze_pkg::pos_t b, maze_pkg::pos_t h);
        int dx;
        int dy;
        dx = int'(b.x) - int'(h.x);
        dy = int'(b.y) - int'(h.y);
        return (dx < maze_pkg::CAPTURE_RADIUS) && (dx > -maze_pkg::CAPTURE_RADIUS)
            && (dy < maze_pkg::CAPTURE_RADIUS) && (dy > -maze_pkg::CAPTURE_RADIUS);
    endfunction

    function automatic maze_pkg::game_state_e drop_result(maze_pkg::pos_t b,
                                                          maze_pkg::layout_t l);
        for (int i = 0; i < maze_pkg::FAIL_HOLES; i++) begin
            if (hole_box(b, l.fail[i])) begin
                return maze_pkg::FAIL;  // fail beats win
            end
        end
        if (hole_box(b, l.win)) begin
            return maze_pkg::WIN;
        end
        return maze_pkg::PLAYING;
    endfunction

    function automatic maze_pkg::coord_t model_step(maze_pkg::coord_t c, maze_pkg::tilt_t t,
                                                    int lim);
        int next;
        next = int'(c) + (int'(t) >>> maze_pkg::TILT_SHIFT);
        if (next < 0) begin
            next = 0;
        end else if (next > lim) begin
            next = lim;
        end
        return maze_pkg::coord_t'(next);
    endfunction

    assign exp_drop     = drop_result(o_ball, o_layout);
    assign in_play_hole = (o_state == maze_pkg::PLAYING) && (exp_drop != maze_pkg::PLAYING);

    // start of a layout is not valid until the first request
    assert property (@(posedge CLK) disable iff (rst)
        !(o_state inside {maze_pkg::NEW_RST, maze_pkg::NEW}) |->
            (o_ball.x <= maze_pkg::POS_X_MAX) && (o_ball.y <= maze_pkg::POS_Y_MAX))
        else stop_on_error("ball position left the playfield");

    assert property (@(posedge CLK) disable iff (rst)
        o_sel < maze_pkg::max_option(o_state, o_mode))
        else stop_on_error("menu cursor ran past the last option");

    assert property (@(posedge CLK) disable iff (rst)
        (o_state == maze_pkg::PAUSE && $past(o_state) == maze_pkg::PAUSE) |-> $stable(o_ball))
        else stop_on_error("ball moved while the game was paused");

    // ball in a hole shows up as FAIL or WIN two cycles later
    assert property (@(posedge CLK) disable iff (rst)
        $rose(in_play_hole) |-> ##2 (o_state == $past(exp_drop, 2)))
        else stop_on_error("hole drop did not give the right state in time");

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [179:0] exp,
                            input logic [179:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("[FAIL] %s: expected %0h, actual %0h", name, exp, act));
        end
    endtask

    task automatic tick();
        @(posedge CLK);
        #2;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (2) tick();
        rst = 1'b0;
    endtask

    // btn is {up, down, ok}
    task automatic press(input logic [2:0] btn);
        {i_up, i_down, i_ok} = btn;
        tick();
        {i_up, i_down, i_ok} = 3'b000;
    endtask

    task automatic pulse_frame();
        i_frame = 1'b1;
        tick();
        i_frame = 1'b0;
    endtask

    task automatic wait_state(input maze_pkg::game_state_e st, input string name);
        int n;
        n = 0;
        while (o_state != st) begin
            if (n == 200) begin
                stop_on_error($sformatf("timed out waiting for %s in %s", st.name(), name));
            end
            tick();
            n++;
        end
    endtask

    // one frame per step, lands on the target once it is in reach
    task automatic roll_to(input maze_pkg::pos_t target, input string name);
        int dx;
        int dy;
        int n;
        n = 0;
        while (o_state == maze_pkg::PLAYING && o_ball != target) begin
            if (n == 40) begin
                stop_on_error($sformatf("ball never reached its target in %s", name));
            end
            dx = int'(target.x) - int'(o_ball.x);
            dy = int'(target.y) - int'(o_ball.y);
            dx = (dx > 31) ? 31 : ((dx < -32) ? -32 : dx);
            dy = (dy > 31) ? 31 : ((dy < -32) ? -32 : dy);
            i_tilt_x = maze_pkg::tilt_t'(dx * 4);
            i_tilt_y = maze_pkg::tilt_t'(dy * 4);
            pulse_frame();
            tick();
            tick();  // hit bit, then state
            n++;
        end
        i_tilt_x = '0;
        i_tilt_y = '0;
    endtask

    task automatic check_layout_range();
        maze_pkg::pos_t p;
        for (int i = 0; i <= maze_pkg::NUM_HOLES; i++) begin
            p = (i < maze_pkg::FAIL_HOLES) ? o_layout.fail[i]
              : (i == maze_pkg::FAIL_HOLES) ? o_layout.win : o_layout.start;
            if (p.x > maze_pkg::POS_X_MAX || p.y > maze_pkg::POS_Y_MAX) begin
                stop_on_error($sformatf("layout coordinate pair %0d is off the playfield", i));
            end
        end
    endtask

    initial begin
        CLK          = 1'b0;
        rst          = 1'b1;
        seed         = 32'hedcb06e0;
        i_tilt_x     = '0;
        i_tilt_y     = '0;
        i_tilt_valid = 1'b0;
        i_frame      = 1'b0;
        i_up         = 1'b0;
        i_down       = 1'b0;
        i_ok         = 1'b0;
        apply_reset();

        check_eq("reset state", maze_pkg::MENU, o_state);
        check_eq("reset cursor", 0, o_sel);
        check_eq("reset ball", {10'd144, 10'd74}, o_ball);

        // ball rolls in the menu too
        i_tilt_valid = 1'b1;
        i_tilt_x     = 8'sd40;
        i_tilt_y     = -8'sd20;
        model_ball   = o_ball;
        repeat (3) begin
            model_ball.x = model_ball.x + 10'd10;
            model_ball.y = model_ball.y - 10'd5;
            pulse_frame();
            check_eq("constant tilt", model_ball, o_ball);
        end
        repeat (60) begin
            i_tilt_x     = maze_pkg::tilt_t'($random(seed));
            i_tilt_y     = maze_pkg::tilt_t'($random(seed));
            model_ball.x = model_step(model_ball.x, i_tilt_x, maze_pkg::POS_X_MAX);
            model_ball.y = model_step(model_ball.y, i_tilt_y, maze_pkg::POS_Y_MAX);
            pulse_frame();
            check_eq("random tilt", model_ball, o_ball);
        end
        i_tilt_x = '0;
        i_tilt_y = '0;

        exp_sel = 0;
        repeat (3) begin
            press(3'b010);
            if (exp_sel < maze_pkg::max_option(maze_pkg::MENU, o_mode) - 1) begin
                exp_sel++;
            end
            check_eq("cursor down", exp_sel, o_sel);
        end
        repeat (3) begin
            press(3'b100);
            if (exp_sel > 0) begin
                exp_sel--;
            end
            check_eq("cursor up", exp_sel, o_sel);
        end

        // classic level 0
        lay = maze_pkg::CLASSIC_TABLE[0];
        press(3'b001);
        wait_state(maze_pkg::PLAYING, "classic start");
        check_eq("classic mode", maze_pkg::CLASSIC, o_mode);
        check_eq("level 0 layout", lay, o_layout);
        roll_to(lay.fail[4], "classic fail hole");
        check_eq("fail state", maze_pkg::FAIL, o_state);
        check_eq("fail drop position", lay.fail[4], o_ball);
        press(3'b001);  // try again
        wait_state(maze_pkg::PLAYING, "classic retry");
        check_eq("retry start", lay.start, o_ball);

        press(3'b001);
        check_eq("pause state", maze_pkg::PAUSE, o_state);
        model_ball = o_ball;
        i_tilt_x   = 8'sd60;
        i_tilt_y   = 8'sd60;
        repeat (3) pulse_frame();
        check_eq("paused ball", model_ball, o_ball);
        press(3'b001);
        check_eq("resume state", maze_pkg::PLAYING, o_state);

        // around the fail holes at y 70 and 130
        roll_to('{x: 10'd144, y: 10'd100}, "win path");
        roll_to('{x: 10'd260, y: 10'd100}, "win path");
        roll_to(lay.win, "classic win hole");
        check_eq("win state", maze_pkg::WIN, o_state);
        check_eq("win drop position", lay.win, o_ball);
        press(3'b010);
        press(3'b001);
        check_eq("next level", 1, o_level);
        wait_state(maze_pkg::PLAYING, "classic level 1");
        check_eq("level 1 layout", maze_pkg::CLASSIC_TABLE[1], o_layout);

        // menu is only reachable again through reset
        apply_reset();
        press(3'b010);
        press(3'b001);
        wait_state(maze_pkg::PLAYING, "endless start");
        check_eq("endless mode", maze_pkg::ENDLESS, o_mode);
        check_layout_range();
        first_layout = o_layout;
        roll_to(o_layout.fail[0], "endless fail hole");
        if (o_state != maze_pkg::FAIL && o_state != maze_pkg::WIN) begin
            stop_on_error("endless game did not end in a hole");
        end
        press(3'b010);  // new game, also option 1 if the win hole was on the way
        press(3'b001);
        wait_state(maze_pkg::PLAYING, "second endless game");
        check_layout_range();
        if (o_layout == first_layout) begin
            stop_on_error("second endless layout repeats the first one");
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
maze_pkg.sv
layout_gen.sv
hole_detector.sv
drop_arbiter.sv
ball_motion.sv
game_fsm.sv
maze_game_top.sv
tb_maze_game.sv
